// File: common/pipePkg.sv
package pipePkg;

    // datapath widths
    localparam int tagWidth = 8;
    localparam int pcWidth = 32;

    // issue queue sizing
    localparam int queueDepth = 8;
    localparam int queueSlack = 2;
    localparam int queuePtrWidth = $clog2(queueDepth);
    localparam int queueCountWidth = $clog2(queueDepth + 1);

    // packet as delivered by fetch, events already marked
    typedef struct packed {
        logic [pcWidth-1:0] pc;
        logic [tagWidth-1:0] tag;
        logic isBranch;
        logic isExcp;
        logic [pcWidth-1:0] target;
    } fetchPacket;

    // payload of every stage register
    typedef struct packed {
        logic valid;
        fetchPacket pkt;
    } microOp;

    // per-stage stall and flush controls
    typedef struct packed {
        logic stallF;
        logic stallF2;
        logic flushF2;
        logic stallD;
        logic flushD;
        logic stallI;
        logic stallIDe;
        logic flushI;
        logic flushQueue;
        logic stallE;
        logic flushE;
        logic stallM;
        logic flushM;
        logic stallM2;
        logic flushM2;
        logic flushW;
    } hazardCtrl;

    // where fetch restarts after a flush
    typedef struct packed {
        logic [tagWidth-1:0] tag;
        logic [pcWidth-1:0] target;
    } redirectInfo;

endpackage

// File: source/stageReg.sv
`timescale 1ns/10ps

// payload must carry a valid field, which flush and reset clear
module stageReg #(
    parameter type payloadType = pipePkg::microOp
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       flush,
    input  payloadType in,
    output payloadType out
);

    // flush inserts a bubble, stall keeps the current content
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out.valid <= 1'b0;
        end else if (!stall) begin
            out <= in;
        end
    end

endmodule

// File: frontPipe/issueQueue.sv
`timescale 1ns/10ps

module issueQueue (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  pipePkg::fetchPacket pushData,
    input  logic                pop,
    output logic                popValid,
    output pipePkg::fetchPacket popData,
    input  logic                flush,
    input  logic                stallDe,
    output logic                overflow
);

    pipePkg::fetchPacket entries [pipePkg::queueDepth];

    logic [pipePkg::queuePtrWidth-1:0] wrPtr;
    logic [pipePkg::queuePtrWidth-1:0] rdPtr;
    logic [pipePkg::queueCountWidth-1:0] count;
    logic doPush;
    logic doPop;

    // enqueue keeps going while dequeue is held
    assign doPush = push && !flush && (count < pipePkg::queueCountWidth'(pipePkg::queueDepth));
    assign doPop = pop && !flush && !stallDe && popValid;

    // an entry is visible the cycle after it is written
    assign popValid = (count != '0);
    assign popData = entries[rdPtr];

    // raised early so that packets in fetch-2 and decode still fit
    assign overflow = (pipePkg::queueDepth - int'(count)) < pipePkg::queueSlack;

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                if (wrPtr == pipePkg::queuePtrWidth'(pipePkg::queueDepth - 1)) begin
                    wrPtr <= '0;
                end else begin
                    wrPtr <= wrPtr + 1'b1;
                end
            end
            if (doPop) begin
                if (rdPtr == pipePkg::queuePtrWidth'(pipePkg::queueDepth - 1)) begin
                    rdPtr <= '0;
                end else begin
                    rdPtr <= rdPtr + 1'b1;
                end
            end
            // simultaneous push and pop leaves count as it is
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: frontPipe/frontPipe.sv
`timescale 1ns/10ps

module frontPipe (
    input  logic                clk,
    input  logic                reset,
    input  logic                fetchValid,
    input  pipePkg::fetchPacket fetchIn,
    input  pipePkg::hazardCtrl  ctrl,
    output pipePkg::microOp     issueOut,
    output logic                branchI,
    output logic                overflowI
);

    pipePkg::microOp fetch2In;
    pipePkg::microOp fetch2Out;
    pipePkg::microOp decodeOut;
    pipePkg::microOp issueIn;

    logic queuePush;
    logic queuePop;
    logic queueValid;
    pipePkg::fetchPacket queueData;

    // strobe offered during a fetch stall is dropped
    always_comb begin
        fetch2In.valid = fetchValid && !ctrl.stallF;
        fetch2In.pkt = fetchIn;
    end

    stageReg #(.payloadType(pipePkg::microOp)) fetch2Reg (
        .clk  (clk),
        .reset(reset),
        .stall(ctrl.stallF2),
        .flush(ctrl.flushF2),
        .in   (fetch2In),
        .out  (fetch2Out)
    );

    stageReg #(.payloadType(pipePkg::microOp)) decodeReg (
        .clk  (clk),
        .reset(reset),
        .stall(ctrl.stallD),
        .flush(ctrl.flushD),
        .in   (fetch2Out),
        .out  (decodeOut)
    );

    // decode hands its packet over only when it moves on
    assign queuePush = decodeOut.valid && !ctrl.stallD && !ctrl.flushD && !ctrl.stallI;

    // dequeue hold comes in through stallDe
    assign queuePop = !ctrl.flushI;

    issueQueue queue (
        .clk     (clk),
        .reset   (reset),
        .push    (queuePush),
        .pushData(decodeOut.pkt),
        .pop     (queuePop),
        .popValid(queueValid),
        .popData (queueData),
        .flush   (ctrl.flushQueue),
        .stallDe (ctrl.stallIDe),
        .overflow(overflowI)
    );

    always_comb begin
        issueIn.valid = queueValid && queuePop;
        issueIn.pkt = queueData;
    end

    stageReg #(.payloadType(pipePkg::microOp)) issueReg (
        .clk  (clk),
        .reset(reset),
        .stall(ctrl.stallIDe),
        .flush(ctrl.flushI),
        .in   (issueIn),
        .out  (issueOut)
    );

    assign branchI = issueOut.valid && issueOut.pkt.isBranch;

endmodule

// File: backPipe/backPipe.sv
`timescale 1ns/10ps

module backPipe (
    input  logic                clk,
    input  logic                reset,
    input  pipePkg::hazardCtrl  ctrl,
    input  pipePkg::microOp     issueIn,
    output logic                excpM,
    output logic                excpW,
    output pipePkg::microOp     memOut,
    output pipePkg::microOp     wbOut,
    output logic                retireValid,
    output pipePkg::fetchPacket retireOut
);

    pipePkg::microOp execOut;
    pipePkg::microOp mem2In;
    pipePkg::microOp mem2Out;

    stageReg #(.payloadType(pipePkg::microOp)) execReg (
        .clk  (clk),
        .reset(reset),
        .stall(ctrl.stallE),
        .flush(ctrl.flushE),
        .in   (issueIn),
        .out  (execOut)
    );

    stageReg #(.payloadType(pipePkg::microOp)) memReg (
        .clk  (clk),
        .reset(reset),
        .stall(ctrl.stallM),
        .flush(ctrl.flushM),
        .in   (execOut),
        .out  (memOut)
    );

    assign excpM = memOut.valid && memOut.pkt.isExcp;

    // faulting packet stops here once it has been reported
    always_comb begin
        mem2In = memOut;
        mem2In.valid = memOut.valid && !memOut.pkt.isExcp;
    end

    stageReg #(.payloadType(pipePkg::microOp)) mem2Reg (
        .clk  (clk),
        .reset(reset),
        .stall(ctrl.stallM2),
        .flush(ctrl.flushM2),
        .in   (mem2In),
        .out  (mem2Out)
    );

    // writeback is never stalled
    stageReg #(.payloadType(pipePkg::microOp)) wbReg (
        .clk  (clk),
        .reset(reset),
        .stall(1'b0),
        .flush(ctrl.flushW),
        .in   (mem2Out),
        .out  (wbOut)
    );

    assign excpW = wbOut.valid && wbOut.pkt.isExcp;

    assign retireValid = wbOut.valid && !wbOut.pkt.isExcp && !ctrl.flushW;
    assign retireOut = wbOut.pkt;

endmodule

// File: source/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    input  logic               clk,
    input  logic               reset,
    input  logic               branchI,
    input  logic               iWait,
    input  logic               dWait,
    input  logic               eWait,
    input  logic               overflowI,
    input  logic               excpM,
    input  logic               excpW,
    output pipePkg::hazardCtrl ctrl
);

    // redirect seen while fetch was still busy
    logic excpPending;
    logic excpPendingNext;
    logic branchPending;
    logic branchPendingNext;

    always_ff @(posedge clk) begin
        if (reset) begin
            excpPending <= 1'b0;
            branchPending <= 1'b0;
        end else begin
            excpPending <= excpPendingNext;
            branchPending <= branchPendingNext;
        end
    end

    always_comb begin
        ctrl = '0;
        excpPendingNext = excpPending;
        branchPendingNext = branchPending;

        if (excpW || excpM) begin
            // everything younger than the faulting packet goes
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            ctrl.flushI = 1'b1;
            ctrl.flushQueue = 1'b1;
            ctrl.flushE = 1'b1;
            ctrl.flushM = 1'b1;
            if (excpW) begin
                ctrl.flushM2 = 1'b1;
                ctrl.flushW = 1'b1;
            end
            if (iWait) begin
                ctrl.stallF = 1'b1;
                excpPendingNext = 1'b1;
            end
        end else if (dWait) begin
            // hold through memory, bubble into memory-2
            ctrl.stallF = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD = 1'b1;
            ctrl.stallI = 1'b1;
            ctrl.stallIDe = 1'b1;
            ctrl.stallE = 1'b1;
            ctrl.stallM = 1'b1;
            ctrl.flushM2 = 1'b1;
        end else if (eWait) begin
            // issue and execute hold, the front keeps filling the queue
            ctrl.stallIDe = 1'b1;
            ctrl.stallE = 1'b1;
            ctrl.flushM = 1'b1;
            if (overflowI) begin
                ctrl.stallF = 1'b1;
                ctrl.stallF2 = 1'b1;
                ctrl.stallD = 1'b1;
                ctrl.stallI = 1'b1;
            end else if (iWait) begin
                ctrl.stallF = 1'b1;
                ctrl.flushF2 = 1'b1;
            end
        end else if (branchI) begin
            // the branch itself moves on to execute
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            ctrl.flushI = 1'b1;
            ctrl.flushQueue = 1'b1;
            if (iWait) begin
                ctrl.stallF = 1'b1;
                branchPendingNext = 1'b1;
            end
        end else if (overflowI) begin
            // queue keeps draining into issue
            ctrl.stallF = 1'b1;
            ctrl.stallF2 = 1'b1;
            ctrl.stallD = 1'b1;
            ctrl.stallI = 1'b1;
        end else if (iWait) begin
            ctrl.stallF = 1'b1;
            ctrl.flushF2 = 1'b1;
        end

        // fetch released, drop the stale packet it delivers
        if (!ctrl.stallF && excpPending) begin
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            excpPendingNext = 1'b0;
        end
        if (!ctrl.stallF && branchPending) begin
            ctrl.flushF2 = 1'b1;
            ctrl.flushD = 1'b1;
            branchPendingNext = 1'b0;
        end
    end

endmodule

// File: source/pipeControl.sv
`timescale 1ns/10ps

module pipeControl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fetchValid,
    input  pipePkg::fetchPacket  fetchIn,
    input  logic                 iWait,
    input  logic                 dWait,
    input  logic                 eWait,
    output logic                 fetchStall,
    output logic                 retireValid,
    output pipePkg::fetchPacket  retireOut,
    output logic                 redirectValid,
    output pipePkg::redirectInfo redirectOut
);

    pipePkg::hazardCtrl ctrl;
    pipePkg::microOp issueOut;
    pipePkg::microOp memOut;
    pipePkg::microOp wbOut;
    pipePkg::microOp redirectSrc;

    logic branchI;
    logic overflowI;
    logic excpM;
    logic excpW;

    frontPipe front (
        .clk       (clk),
        .reset     (reset),
        .fetchValid(fetchValid),
        .fetchIn   (fetchIn),
        .ctrl      (ctrl),
        .issueOut  (issueOut),
        .branchI   (branchI),
        .overflowI (overflowI)
    );

    backPipe back (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .issueIn    (issueOut),
        .excpM      (excpM),
        .excpW      (excpW),
        .memOut     (memOut),
        .wbOut      (wbOut),
        .retireValid(retireValid),
        .retireOut  (retireOut)
    );

    hazardUnit hazard (
        .clk      (clk),
        .reset    (reset),
        .branchI  (branchI),
        .iWait    (iWait),
        .dWait    (dWait),
        .eWait    (eWait),
        .overflowI(overflowI),
        .excpM    (excpM),
        .excpW    (excpW),
        .ctrl     (ctrl)
    );

    assign fetchStall = ctrl.stallF;

    // queue flush marks the cycle an exception or a branch is taken
    assign redirectValid = ctrl.flushQueue;

    // oldest exception first, otherwise the branch in issue
    always_comb begin
        if (excpW) begin
            redirectSrc = wbOut;
        end else if (excpM) begin
            redirectSrc = memOut;
        end else begin
            redirectSrc = issueOut;
        end
        redirectOut.tag = redirectSrc.pkt.tag;
        redirectOut.target = redirectSrc.pkt.target;
    end

endmodule

// File: testbench/pipeChecker.sv
`timescale 1ns/10ps

// scoreboard for pipeControl, keeps accepted packets in program order
module pipeChecker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fetchValid,
    input  pipePkg::fetchPacket  fetchIn,
    input  logic                 iWait,
    input  logic                 dWait,
    input  logic                 eWait,
    input  logic                 fetchStall,
    input  logic                 retireValid,
    input  pipePkg::fetchPacket  retireOut,
    input  logic                 redirectValid,
    input  pipePkg::redirectInfo redirectOut,
    output int                   valueErrors,
    output int                   protocolErrors,
    output int                   lostPackets,
    output int                   outstanding,
    output int                   retiredCount,
    output int                   overflowStalls
);

    typedef struct packed {
        pipePkg::fetchPacket pkt;
        logic redirected;
    } flightEntry;

    flightEntry inFlight [$];
    // first fetch after a redirect during iWait is stale
    logic dropNext;
    // consecutive cycles with the back pipe held
    int waitCycles;

    task automatic checkRetire();
        int idx;
        int i;
        idx = -1;
        if (inFlight.size() == 0) begin
            $display("tag %0d retired at %0t with no packet in flight", retireOut.tag, $time);
            protocolErrors++;
        end else if (retireOut.tag == inFlight[0].pkt.tag) begin
            if (inFlight[0].pkt.isExcp) begin
                $display("Fail %0t: exception packet tag %0d retired", $time, retireOut.tag);
                valueErrors++;
            end else if (inFlight[0].pkt.isBranch && !inFlight[0].redirected) begin
                $display("Fail %0t: branch tag %0d retired without a redirect", $time,
                         retireOut.tag);
                valueErrors++;
            end else if (retireOut != inFlight[0].pkt) begin
                $display("Fail %0t: tag %0d retired with wrong pc or target", $time,
                         retireOut.tag);
                valueErrors++;
            end
            void'(inFlight.pop_front());
            retiredCount++;
        end else begin
            $display("Fail %0t: retired tag %0d, expected tag %0d", $time, retireOut.tag,
                     inFlight[0].pkt.tag);
            valueErrors++;
            for (i = 0; i < inFlight.size(); i++) begin
                if (idx < 0 && inFlight[i].pkt.tag == retireOut.tag) begin
                    idx = i;
                end
            end
            // resync past the packets that went missing
            if (idx > 0) begin
                lostPackets += idx;
                repeat (idx + 1) void'(inFlight.pop_front());
            end
        end
    endtask

    task automatic applyRedirect();
        flightEntry entry;
        int idx;
        int i;
        idx = -1;
        for (i = 0; i < inFlight.size(); i++) begin
            if (inFlight[i].pkt.tag == redirectOut.tag) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("redirect at %0t names tag %0d, which is not in flight", $time,
                     redirectOut.tag);
            protocolErrors++;
        end else begin
            entry = inFlight[idx];
            if (!entry.pkt.isBranch && !entry.pkt.isExcp) begin
                $display("Fail %0t: redirect for tag %0d without an event", $time, entry.pkt.tag);
                valueErrors++;
            end
            if (entry.redirected) begin
                $display("second redirect for tag %0d at %0t", entry.pkt.tag, $time);
                protocolErrors++;
            end
            if (redirectOut.target != entry.pkt.target) begin
                $display("Fail %0t: redirect target %h, expected %h", $time,
                         redirectOut.target, entry.pkt.target);
                valueErrors++;
            end
            // everything younger is discarded
            while (inFlight.size() > idx + 1) begin
                void'(inFlight.pop_back());
            end
            if (entry.pkt.isExcp) begin
                void'(inFlight.pop_back());
            end else begin
                entry.redirected = 1'b1;
                inFlight[idx] = entry;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            inFlight.delete();
            dropNext = 1'b0;
            waitCycles = 0;
            valueErrors = 0;
            protocolErrors = 0;
            lostPackets = 0;
            retiredCount = 0;
            outstanding = 0;
            overflowStalls = 0;
        end else begin
            if (iWait && !fetchStall) begin
                $display("fetchStall low at %0t while iWait is high", $time);
                protocolErrors++;
            end
            // no wait input high, so only the queue can hold fetch
            if (fetchStall && !iWait && !dWait && !eWait) begin
                overflowStalls++;
            end
            // memory-2 and writeback have drained after three held cycles
            if (retireValid && (dWait || eWait) && waitCycles >= 3) begin
                $display("tag %0d retired at %0t while the back pipe was held",
                         retireOut.tag, $time);
                protocolErrors++;
            end
            if (dWait || eWait) begin
                waitCycles++;
            end else begin
                waitCycles = 0;
            end
            if (retireValid) begin
                checkRetire();
            end
            if (!fetchStall) begin
                if (dropNext) begin
                    dropNext = 1'b0;
                end else if (fetchValid) begin
                    inFlight.push_back(flightEntry'({fetchIn, 1'b0}));
                end
            end
            // same-cycle fetch counts as younger than the redirect
            if (redirectValid) begin
                applyRedirect();
                if (fetchStall) begin
                    dropNext = 1'b1;
                end
            end
            outstanding = inFlight.size();
        end
    end

endmodule

// File: testbench/pipeControlTb.sv
`timescale 1ns/10ps

module pipeControlTb;

    // flag order fetchValid isBranch isExcp iWait dWait eWait randomLen
    typedef struct packed {
        logic fetchValid;
        logic isBranch;
        logic isExcp;
        logic iWait;
        logic dWait;
        logic eWait;
        logic randomLen;
        int count;
    } stimRow;

    logic clk = 1'b0;
    logic reset;
    logic fetchValid;
    pipePkg::fetchPacket fetchIn;
    logic iWait;
    logic dWait;
    logic eWait;
    logic fetchStall;
    logic retireValid;
    pipePkg::fetchPacket retireOut;
    logic redirectValid;
    pipePkg::redirectInfo redirectOut;

    int valueErrors;
    int protocolErrors;
    int lostPackets;
    int outstanding;
    int retiredCount;
    int overflowStalls;

    stimRow rows [$];
    logic [pipePkg::tagWidth-1:0] nextTag;
    int cycleCount = 0;
    int cycleLimit = 0;

    always #10 clk = ~clk;

    pipeControl DUT (.*);

    pipeChecker scoreboard (.*);

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles with %0d packets still in flight", cycleCount,
                     outstanding);
            $display("sim failed");
            $finish;
        end
    end

    function automatic pipePkg::fetchPacket makePacket(input logic [7:0] tag,
                                                       input logic isBranch,
                                                       input logic isExcp);
        pipePkg::fetchPacket pkt;
        pkt.pc = 32'h0000_1000 + {22'd0, tag, 2'b00};
        pkt.tag = tag;
        pkt.isBranch = isBranch;
        pkt.isExcp = isExcp;
        // targets in their own region so a swap shows up
        pkt.target = 32'h0008_0000 + {20'd0, tag, 4'h0};
        return pkt;
    endfunction

    task automatic addRow(input logic [6:0] flags, input int count);
        rows.push_back(stimRow'({flags, count}));
    endtask

    task automatic applyRow(input stimRow row);
        int n;
        for (n = 0; n < row.count; n++) begin
            @(negedge clk);
            iWait = row.iWait;
            dWait = row.dWait;
            eWait = row.eWait;
            // let fetchStall settle on the new wait inputs
            #1;
            if (row.fetchValid && !fetchStall) begin
                fetchValid = 1'b1;
                fetchIn = makePacket(nextTag, row.isBranch, row.isExcp);
                nextTag = nextTag + 1'b1;
            end else begin
                fetchValid = 1'b0;
            end
        end
    endtask

    task automatic loadRows();
        addRow(7'b1000000, 12);
        addRow(7'b0000000, 8);
        addRow(7'b1000000, 6);
        addRow(7'b0000101, 0);
        addRow(7'b1000000, 4);
        addRow(7'b0000011, 0);
        // branch reaches issue four cycles after fetch
        addRow(7'b1000000, 3);
        addRow(7'b1100000, 1);
        addRow(7'b1000000, 6);
        addRow(7'b0000000, 10);
        addRow(7'b1000000, 3);
        addRow(7'b1010000, 1);
        addRow(7'b1000000, 6);
        addRow(7'b0000000, 10);
        // events that land while fetch waits
        addRow(7'b1100000, 1);
        addRow(7'b1000000, 3);
        addRow(7'b1001001, 0);
        addRow(7'b1000000, 3);
        addRow(7'b1010000, 1);
        addRow(7'b1000000, 5);
        addRow(7'b1001001, 0);
        // long burst held up in execute
        addRow(7'b1000000, 20);
        addRow(7'b1000010, 6);
        addRow(7'b1000000, 10);
        addRow(7'b0000000, 16);
    endtask

    initial begin
        stimRow row;
        int r;
        int total;
        reset = 1'b1;
        fetchValid = 1'b0;
        fetchIn = '0;
        iWait = 1'b0;
        dWait = 1'b0;
        eWait = 1'b0;
        nextTag = '0;
        void'($urandom(46981));
        loadRows();
        total = 0;
        for (r = 0; r < rows.size(); r++) begin
            row = rows[r];
            if (row.randomLen) begin
                row.count = int'($urandom_range(6, 3));
                rows[r] = row;
            end
            total += row.count;
        end
        cycleLimit = 4 * total + 100;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        for (r = 0; r < rows.size(); r++) begin
            applyRow(rows[r]);
        end
        while (outstanding != 0) begin
            @(negedge clk);
        end
        if (overflowStalls == 0) begin
            $display("fetchStall never rose through queue overflow during the burst");
        end
        $display("errors: %0d wrong values, %0d protocol, %0d lost packets, %0d retired, %0d %s",
                 valueErrors, protocolErrors, lostPackets, retiredCount, overflowStalls,
                 "overflow stalls");
        if (valueErrors + protocolErrors + lostPackets == 0 && overflowStalls != 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: compile.f
common/pipePkg.sv
source/stageReg.sv
frontPipe/issueQueue.sv
frontPipe/frontPipe.sv
backPipe/backPipe.sv
source/hazardUnit.sv
source/pipeControl.sv
testbench/pipeChecker.sv
testbench/pipeControlTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pipeControl testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --timescale 1ns/10ps --top-module pipeControlTb \
    -f compile.f -o pipeControlSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/pipeControlSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
